/* source/backend_pkg.sv */
package backend_pkg;

  // Register file geometry
  localparam int RegAddrW = 5;
  localparam int NumRegs  = 32;

  // Every instruction is four bytes, there are no compressed forms
  localparam int PcStep = 4;

  // Pre-decoded micro-op kinds delivered by the frontend
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_ADDI,
    OP_BEQ,
    OP_JAL,
    OP_MUL
  } op_e;

  // Where a pipeline stage takes its result from
  typedef enum logic {
    FU_ALU,
    FU_MUL
  } fu_e;

endpackage

/* source/alu.sv */
module alu import backend_pkg::*; #(
  parameter int Xlen = 32
) (
  input  op_e             op_i,
  input  logic [Xlen-1:0] pc_i,
  input  logic [Xlen-1:0] imm_i,
  input  logic [Xlen-1:0] rs1_i,
  input  logic [Xlen-1:0] rs2_i,
  output logic [Xlen-1:0] result_o,
  output logic [Xlen-1:0] link_o,
  output logic            br_taken_o,
  output logic [Xlen-1:0] target_o
);

  logic            sub;
  logic [Xlen-1:0] operand_b;
  logic [Xlen-1:0] sum;

  // One adder serves add, sub and add-immediate
  assign sub       = (op_i == OP_SUB);
  assign operand_b = (op_i == OP_ADDI) ? imm_i : rs2_i;
  assign sum       = rs1_i + (sub ? ~operand_b : operand_b) + Xlen'(sub);

  always_comb begin
    unique case (op_i)
      OP_AND:  result_o = rs1_i & rs2_i;
      OP_XOR:  result_o = rs1_i ^ rs2_i;
      default: result_o = sum;
    endcase
  end

  // Branch and jump side
  assign link_o   = pc_i + Xlen'(PcStep);
  assign target_o = pc_i + imm_i;

  always_comb begin
    unique case (op_i)
      OP_BEQ:  br_taken_o = (rs1_i == rs2_i);
      OP_JAL:  br_taken_o = 1'b1;
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule

/* source/mul_unit.sv */
module mul_unit #(
  parameter int Xlen        = 32,
  parameter int MulStepBits = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  logic [Xlen-1:0] a_i,
  input  logic [Xlen-1:0] b_i,
  output logic            busy_o,
  output logic            done_o,
  output logic [Xlen-1:0] product_o
);

  localparam int NumSteps = Xlen / MulStepBits;
  localparam int CntW     = $clog2(NumSteps + 1);

  logic [CntW-1:0] count_q;
  logic            done_q;
  logic [Xlen-1:0] acc_q;
  logic [Xlen-1:0] mcand_q;
  logic [Xlen-1:0] mplier_q;

  // Multiplicand times one digit of the multiplier
  function automatic logic [Xlen-1:0] partial(input logic [Xlen-1:0]        mcand,
                                               input logic [MulStepBits-1:0] digit);
    logic [Xlen-1:0] sum;
    sum = '0;
    for (int i = 0; i < MulStepBits; i++) begin
      if (digit[i]) begin
        sum = sum + (mcand << i);
      end
    end
    return sum;
  endfunction

  // The first digit is consumed on the start edge itself
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      done_q  <= 1'b0;
    end else if (start_i) begin
      count_q <= CntW'(NumSteps - 1);
      done_q  <= (NumSteps == 1);
    end else begin
      done_q <= (count_q == CntW'(1));
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_q    <= partial(a_i, b_i[MulStepBits-1:0]);
      mcand_q  <= a_i << MulStepBits;
      mplier_q <= b_i >> MulStepBits;
    end else if (count_q != '0) begin
      acc_q    <= acc_q + partial(mcand_q, mplier_q[MulStepBits-1:0]);
      mcand_q  <= mcand_q << MulStepBits;
      mplier_q <= mplier_q >> MulStepBits;
    end
  end

  assign busy_o    = (count_q != '0);
  assign done_o    = done_q;
  assign product_o = acc_q;

endmodule

/* source/reg_file.sv */
module reg_file import backend_pkg::*; #(
  parameter int Xlen = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [RegAddrW-1:0] raddr_a_i,
  input  logic [RegAddrW-1:0] raddr_b_i,
  input  logic                we_i,
  input  logic [RegAddrW-1:0] waddr_i,
  input  logic [Xlen-1:0]     wdata_i,
  output logic [Xlen-1:0]     rdata_a_o,
  output logic [Xlen-1:0]     rdata_b_o
);

  logic [Xlen-1:0]     regs_q [NumRegs];
  logic [RegAddrW-1:0] raddr_a_q;
  logic [RegAddrW-1:0] raddr_b_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      raddr_a_q <= '0;
      raddr_b_q <= '0;
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      raddr_a_q <= raddr_a_i;
      raddr_b_q <= raddr_b_i;
      // x0 stays zero
      if (we_i && waddr_i != '0) begin
        regs_q[waddr_i] <= wdata_i;
      end
    end
  end

  // Read data follows the address latched one edge earlier
  assign rdata_a_o = regs_q[raddr_a_q];
  assign rdata_b_o = regs_q[raddr_b_q];

endmodule

/* source/issue_ctrl.sv */
module issue_ctrl import backend_pkg::*; #(
  parameter int Xlen = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  logic [Xlen-1:0]     fetch_pc_i,
  input  op_e                 fetch_op_i,
  input  logic [RegAddrW-1:0] fetch_rd_i,
  input  logic [RegAddrW-1:0] fetch_rs1_i,
  input  logic [RegAddrW-1:0] fetch_rs2_i,
  input  logic [Xlen-1:0]     fetch_imm_i,
  input  logic                fetch_redirected_i,
  output logic                fetch_ready_o,
  output logic [RegAddrW-1:0] rf_raddr_a_o,
  output logic [RegAddrW-1:0] rf_raddr_b_o,
  input  logic [Xlen-1:0]     rf_rdata_a_i,
  input  logic [Xlen-1:0]     rf_rdata_b_i,
  input  logic                ex1_pending_i,
  input  logic [RegAddrW-1:0] ex1_rd_i,
  input  logic                ex1_data_valid_i,
  input  logic [Xlen-1:0]     ex1_data_i,
  input  logic                ex2_pending_i,
  input  logic [RegAddrW-1:0] ex2_rd_i,
  input  logic                ex2_data_valid_i,
  input  logic [Xlen-1:0]     ex2_data_i,
  input  logic                ex_ready_i,
  input  logic                mul_busy_i,
  input  logic                br_taken_i,
  input  logic [Xlen-1:0]     br_target_i,
  output logic                issue_o,
  output op_e                 op_o,
  output logic [RegAddrW-1:0] rd_o,
  output logic [Xlen-1:0]     pc_o,
  output logic [Xlen-1:0]     imm_o,
  output logic [Xlen-1:0]     rs1_val_o,
  output logic [Xlen-1:0]     rs2_val_o,
  output logic                redirect_valid_o,
  output logic [Xlen-1:0]     redirect_pc_o
);

  typedef enum logic {
    ST_NORMAL,
    ST_MISPREDICT
  } state_e;

  //////////////////////////////////////////////////////////////////////
  // Decode register
  //////////////////////////////////////////////////////////////////////

  logic                de_valid_q;
  logic [Xlen-1:0]     de_pc_q;
  op_e                 de_op_q;
  logic [RegAddrW-1:0] de_rd_q;
  logic [RegAddrW-1:0] de_rs1_q;
  logic [RegAddrW-1:0] de_rs2_q;
  logic [Xlen-1:0]     de_imm_q;
  logic                de_redirected_q;

  logic fetch_accept;
  logic de_ready;

  assign fetch_accept  = fetch_valid_i && fetch_ready_o;
  assign fetch_ready_o = !de_valid_q || de_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      de_valid_q <= 1'b0;
    end else if (fetch_accept) begin
      de_valid_q <= 1'b1;
    end else if (de_ready) begin
      de_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_accept) begin
      de_pc_q         <= fetch_pc_i;
      de_op_q         <= fetch_op_i;
      de_rd_q         <= fetch_rd_i;
      de_rs1_q        <= fetch_rs1_i;
      de_rs2_q        <= fetch_rs2_i;
      de_imm_q        <= fetch_imm_i;
      de_redirected_q <= fetch_redirected_i;
    end
  end

  // The register file latches its address, so keep presenting the held one
  assign rf_raddr_a_o = fetch_accept ? fetch_rs1_i : de_rs1_q;
  assign rf_raddr_b_o = fetch_accept ? fetch_rs2_i : de_rs2_q;

  //////////////////////////////////////////////////////////////////////
  // Bypass and hazards
  //////////////////////////////////////////////////////////////////////

  logic rs1_hazard;
  logic rs2_hazard;
  logic data_hazard;
  logic struct_hazard;
  logic control_hazard;

  // Returns {hazard, operand}; EX1 is younger and wins over EX2
  function automatic logic [Xlen:0] bypass(input logic [RegAddrW-1:0] rs,
                                           input logic [Xlen-1:0]     rf_val);
    logic            hazard;
    logic [Xlen-1:0] val;
    hazard = 1'b0;
    val    = rf_val;
    if (rs != '0 && ex2_pending_i && ex2_rd_i == rs) begin
      if (ex2_data_valid_i) begin
        val = ex2_data_i;
      end else begin
        hazard = 1'b1;
      end
    end
    if (rs != '0 && ex1_pending_i && ex1_rd_i == rs) begin
      if (ex1_data_valid_i) begin
        val = ex1_data_i;
      end else begin
        hazard = 1'b1;
      end
    end
    return {hazard, val};
  endfunction

  assign {rs1_hazard, rs1_val_o} = bypass(de_rs1_q, rf_rdata_a_i);
  assign {rs2_hazard, rs2_val_o} = bypass(de_rs2_q, rf_rdata_b_i);

  assign data_hazard   = rs1_hazard || rs2_hazard;
  // Only one multiply may be in flight
  assign struct_hazard = !ex_ready_i || (de_op_q == OP_MUL && mul_busy_i);

  //////////////////////////////////////////////////////////////////////
  // Mispredict tracking
  //////////////////////////////////////////////////////////////////////

  state_e          state_q;
  state_e          state_d;
  logic [Xlen-1:0] exp_pc_q;
  logic            pc_mismatch;

  assign pc_mismatch = (exp_pc_q != de_pc_q);

  // Wrong-path instructions are consumed without issue
  assign control_hazard = (state_q == ST_NORMAL) ? pc_mismatch : !de_redirected_q;

  assign issue_o  = de_valid_q && !data_hazard && !struct_hazard && !control_hazard;
  assign de_ready = (!data_hazard && !struct_hazard) || control_hazard;

  always_comb begin
    state_d = state_q;
    if (de_valid_q) begin
      if (state_q == ST_NORMAL && pc_mismatch) begin
        state_d = ST_MISPREDICT;
      end
      // Frontend has restarted at the expected PC
      if (state_q == ST_MISPREDICT && de_redirected_q) begin
        state_d = ST_NORMAL;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_NORMAL;
      exp_pc_q <= '0;
    end else begin
      state_q <= state_d;
      if (issue_o) begin
        exp_pc_q <= br_taken_i ? br_target_i : de_pc_q + Xlen'(PcStep);
      end
    end
  end

  assign redirect_valid_o = (state_q == ST_NORMAL) && de_valid_q && pc_mismatch;
  assign redirect_pc_o    = exp_pc_q;

  assign op_o  = de_op_q;
  assign rd_o  = de_rd_q;
  assign pc_o  = de_pc_q;
  assign imm_o = de_imm_q;

endmodule

/* source/ex_pipe.sv */
module ex_pipe import backend_pkg::*; #(
  parameter int Xlen = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_i,
  input  op_e                 op_i,
  input  logic [RegAddrW-1:0] rd_i,
  input  logic [Xlen-1:0]     pc_i,
  input  logic [Xlen-1:0]     alu_result_i,
  input  logic [Xlen-1:0]     link_i,
  input  logic                mul_done_i,
  input  logic [Xlen-1:0]     mul_product_i,
  output logic                ex1_pending_o,
  output logic [RegAddrW-1:0] ex1_rd_o,
  output logic                ex1_data_valid_o,
  output logic [Xlen-1:0]     ex1_data_o,
  output logic                ex2_pending_o,
  output logic [RegAddrW-1:0] ex2_rd_o,
  output logic                ex2_data_valid_o,
  output logic [Xlen-1:0]     ex2_data_o,
  output logic                ex_ready_o,
  output logic                rf_we_o,
  output logic [RegAddrW-1:0] rf_waddr_o,
  output logic [Xlen-1:0]     rf_wdata_o,
  output logic                commit_valid_o,
  output logic [Xlen-1:0]     commit_pc_o,
  output logic [RegAddrW-1:0] commit_rd_o,
  output logic [Xlen-1:0]     commit_data_o
);

  logic                ex1_pending_q;
  fu_e                 ex1_select_q;
  logic [Xlen-1:0]     ex1_alu_data_q;
  logic [Xlen-1:0]     ex1_pc_q;
  logic [RegAddrW-1:0] ex1_rd_q;

  logic                ex2_pending_q;
  fu_e                 ex2_select_q;
  logic [Xlen-1:0]     ex2_alu_data_q;
  logic [Xlen-1:0]     ex2_pc_q;
  logic [RegAddrW-1:0] ex2_rd_q;

  logic                ex2_ready;
  logic                advance;
  logic                retire;
  logic [Xlen-1:0]     issue_data;
  logic [RegAddrW-1:0] issue_rd;

  // Branches and jumps carry the link value, a branch writes no register
  assign issue_data = (op_i == OP_BEQ || op_i == OP_JAL) ? link_i : alu_result_i;
  assign issue_rd   = (op_i == OP_BEQ) ? '0 : rd_i;

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (ex1_select_q == FU_ALU) begin
      ex1_data_valid_o = 1'b1;
      ex1_data_o       = ex1_alu_data_q;
    end else begin
      ex1_data_valid_o = mul_done_i;
      ex1_data_o       = mul_product_i;
    end
  end

  always_comb begin
    if (ex2_select_q == FU_ALU) begin
      ex2_data_valid_o = 1'b1;
      ex2_data_o       = ex2_alu_data_q;
    end else begin
      ex2_data_valid_o = mul_done_i;
      ex2_data_o       = mul_product_i;
    end
  end

  assign ex2_ready  = !ex2_pending_q || ex2_data_valid_o;
  assign ex_ready_o = ex2_ready || !ex1_pending_q;
  assign advance    = ex1_pending_q && ex2_ready;
  assign retire     = ex2_pending_q && ex2_data_valid_o;

  //////////////////////////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_pending_q <= 1'b0;
      ex1_select_q  <= FU_ALU;
      ex2_pending_q <= 1'b0;
      ex2_select_q  <= FU_ALU;
    end else begin
      if (issue_i) begin
        ex1_pending_q <= 1'b1;
        ex1_select_q  <= (op_i == OP_MUL) ? FU_MUL : FU_ALU;
      end else begin
        if (ex2_ready) begin
          ex1_pending_q <= 1'b0;
        end
        // Valid data is captured locally so the done pulse is not lost
        if (ex2_ready || ex1_data_valid_o) begin
          ex1_select_q <= FU_ALU;
        end
      end

      if (advance) begin
        ex2_pending_q <= 1'b1;
        ex2_select_q  <= ex1_data_valid_o ? FU_ALU : ex1_select_q;
      end else if (retire) begin
        ex2_pending_q <= 1'b0;
        ex2_select_q  <= FU_ALU;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      ex1_alu_data_q <= issue_data;
      ex1_pc_q       <= pc_i;
      ex1_rd_q       <= issue_rd;
    end else if (ex1_data_valid_o) begin
      ex1_alu_data_q <= ex1_data_o;
    end

    if (advance) begin
      ex2_alu_data_q <= ex1_data_o;
      ex2_pc_q       <= ex1_pc_q;
      ex2_rd_q       <= ex1_rd_q;
    end
  end

  assign ex1_pending_o = ex1_pending_q;
  assign ex1_rd_o      = ex1_rd_q;
  assign ex2_pending_o = ex2_pending_q;
  assign ex2_rd_o      = ex2_rd_q;

  // Writeback and commit happen together
  assign rf_we_o        = retire;
  assign rf_waddr_o     = ex2_rd_q;
  assign rf_wdata_o     = ex2_data_o;
  assign commit_valid_o = retire;
  assign commit_pc_o    = ex2_pc_q;
  assign commit_rd_o    = ex2_rd_q;
  assign commit_data_o  = ex2_data_o;

endmodule

/* source/backend_top.sv */
module backend_top import backend_pkg::*; #(
  parameter int Xlen        = 32,
  parameter int MulStepBits = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  logic                fetch_redirected_i,
  input  logic [Xlen-1:0]     fetch_pc_i,
  input  logic [Xlen-1:0]     fetch_imm_i,
  input  op_e                 fetch_op_i,
  input  logic [RegAddrW-1:0] fetch_rd_i,
  input  logic [RegAddrW-1:0] fetch_rs1_i,
  input  logic [RegAddrW-1:0] fetch_rs2_i,
  output logic                fetch_ready_o,
  output logic                redirect_valid_o,
  output logic [Xlen-1:0]     redirect_pc_o,
  output logic                commit_valid_o,
  output logic [Xlen-1:0]     commit_pc_o,
  output logic [RegAddrW-1:0] commit_rd_o,
  output logic [Xlen-1:0]     commit_data_o
);

  // Issue side
  logic                issue;
  op_e                 op;
  logic [RegAddrW-1:0] rd;
  logic [Xlen-1:0]     pc;
  logic [Xlen-1:0]     imm;
  logic [Xlen-1:0]     rs1_val;
  logic [Xlen-1:0]     rs2_val;

  // Register file ports
  logic [RegAddrW-1:0] rf_raddr_a;
  logic [RegAddrW-1:0] rf_raddr_b;
  logic [Xlen-1:0]     rf_rdata_a;
  logic [Xlen-1:0]     rf_rdata_b;
  logic                rf_we;
  logic [RegAddrW-1:0] rf_waddr;
  logic [Xlen-1:0]     rf_wdata;

  // Stage status for bypass
  logic                ex1_pending;
  logic [RegAddrW-1:0] ex1_rd;
  logic                ex1_data_valid;
  logic [Xlen-1:0]     ex1_data;
  logic                ex2_pending;
  logic [RegAddrW-1:0] ex2_rd;
  logic                ex2_data_valid;
  logic [Xlen-1:0]     ex2_data;
  logic                ex_ready;

  // Execution units
  logic [Xlen-1:0]     alu_result;
  logic [Xlen-1:0]     link;
  logic                br_taken;
  logic [Xlen-1:0]     br_target;
  logic                mul_busy;
  logic                mul_done;
  logic [Xlen-1:0]     mul_product;

  issue_ctrl #(.Xlen(Xlen)) u_issue_ctrl (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_pc_i,
    .fetch_op_i,
    .fetch_rd_i,
    .fetch_rs1_i,
    .fetch_rs2_i,
    .fetch_imm_i,
    .fetch_redirected_i,
    .fetch_ready_o,
    .rf_raddr_a_o     (rf_raddr_a),
    .rf_raddr_b_o     (rf_raddr_b),
    .rf_rdata_a_i     (rf_rdata_a),
    .rf_rdata_b_i     (rf_rdata_b),
    .ex1_pending_i    (ex1_pending),
    .ex1_rd_i         (ex1_rd),
    .ex1_data_valid_i (ex1_data_valid),
    .ex1_data_i       (ex1_data),
    .ex2_pending_i    (ex2_pending),
    .ex2_rd_i         (ex2_rd),
    .ex2_data_valid_i (ex2_data_valid),
    .ex2_data_i       (ex2_data),
    .ex_ready_i       (ex_ready),
    .mul_busy_i       (mul_busy),
    .br_taken_i       (br_taken),
    .br_target_i      (br_target),
    .issue_o          (issue),
    .op_o             (op),
    .rd_o             (rd),
    .pc_o             (pc),
    .imm_o            (imm),
    .rs1_val_o        (rs1_val),
    .rs2_val_o        (rs2_val),
    .redirect_valid_o,
    .redirect_pc_o
  );

  alu #(.Xlen(Xlen)) u_alu (
    .op_i       (op),
    .pc_i       (pc),
    .imm_i      (imm),
    .rs1_i      (rs1_val),
    .rs2_i      (rs2_val),
    .result_o   (alu_result),
    .link_o     (link),
    .br_taken_o (br_taken),
    .target_o   (br_target)
  );

  mul_unit #(.Xlen(Xlen), .MulStepBits(MulStepBits)) u_mul_unit (
    .clk_i,
    .rst_ni,
    .start_i   (issue && op == OP_MUL),
    .a_i       (rs1_val),
    .b_i       (rs2_val),
    .busy_o    (mul_busy),
    .done_o    (mul_done),
    .product_o (mul_product)
  );

  ex_pipe #(.Xlen(Xlen)) u_ex_pipe (
    .clk_i,
    .rst_ni,
    .issue_i          (issue),
    .op_i             (op),
    .rd_i             (rd),
    .pc_i             (pc),
    .alu_result_i     (alu_result),
    .link_i           (link),
    .mul_done_i       (mul_done),
    .mul_product_i    (mul_product),
    .ex1_pending_o    (ex1_pending),
    .ex1_rd_o         (ex1_rd),
    .ex1_data_valid_o (ex1_data_valid),
    .ex1_data_o       (ex1_data),
    .ex2_pending_o    (ex2_pending),
    .ex2_rd_o         (ex2_rd),
    .ex2_data_valid_o (ex2_data_valid),
    .ex2_data_o       (ex2_data),
    .ex_ready_o       (ex_ready),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .commit_valid_o,
    .commit_pc_o,
    .commit_rd_o,
    .commit_data_o
  );

  reg_file #(.Xlen(Xlen)) u_reg_file (
    .clk_i,
    .rst_ni,
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

endmodule

/* sim/backend_props.sv */
module backend_props
  import backend_pkg::*;
#(
  parameter int Xlen = 32
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                redirect_valid_i,
  input logic [Xlen-1:0]     redirect_pc_i,
  input logic                commit_valid_i,
  input logic [RegAddrW-1:0] commit_rd_i,
  input logic [Xlen-1:0]     commit_data_i,
  input logic [Xlen-1:0]     rf_regs_i [NumRegs]
);

  // Nothing retires or redirects in the first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !commit_valid_i && !redirect_valid_i)
    else $error("commit or redirect active in the cycle after reset release");

  // Redirect targets are whole instructions
  redirect_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    redirect_valid_i |-> redirect_pc_i[1:0] == 2'b00)
    else $error("redirect target is not word aligned");

  // A retired result lands in the register the commit reports
  commit_written: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i && commit_rd_i != '0 |=>
      rf_regs_i[$past(commit_rd_i)] == $past(commit_data_i))
    else $error("committed data missing from the reported register");

endmodule

bind backend_top backend_props #(.Xlen(Xlen)) u_props (
  .clk_i,
  .rst_ni,
  .redirect_valid_i (redirect_valid_o),
  .redirect_pc_i    (redirect_pc_o),
  .commit_valid_i   (commit_valid_o),
  .commit_rd_i      (commit_rd_o),
  .commit_data_i    (commit_data_o),
  .rf_regs_i        (u_reg_file.regs_q)
);

/* sim/backend_tb.sv */
module backend_tb
  import backend_pkg::*;
();

  localparam int Xlen        = 32;
  localparam int MulStepBits = 4;
  localparam int ProgWords   = 64;
  localparam int NumCommits  = 2000;
  localparam int MaxCycles   = 200000;

  logic                clk_i;
  logic                rst_ni;
  logic                fetch_valid;
  logic                fetch_redirected;
  logic [Xlen-1:0]     fetch_pc;
  logic [Xlen-1:0]     fetch_imm;
  op_e                 fetch_op;
  logic [RegAddrW-1:0] fetch_rd;
  logic [RegAddrW-1:0] fetch_rs1;
  logic [RegAddrW-1:0] fetch_rs2;
  logic                fetch_ready;
  logic                redirect_valid;
  logic [Xlen-1:0]     redirect_pc;
  logic                commit_valid;
  logic [Xlen-1:0]     commit_pc;
  logic [RegAddrW-1:0] commit_rd;
  logic [Xlen-1:0]     commit_data;

  // Program image, one micro-op per word
  op_e                 prog_op  [ProgWords];
  logic [RegAddrW-1:0] prog_rd  [ProgWords];
  logic [RegAddrW-1:0] prog_rs1 [ProgWords];
  logic [RegAddrW-1:0] prog_rs2 [ProgWords];
  logic [Xlen-1:0]     prog_imm [ProgWords];

  // Expected retirement stream
  logic [Xlen-1:0]     exp_pc   [NumCommits];
  logic [RegAddrW-1:0] exp_rd   [NumCommits];
  logic [Xlen-1:0]     exp_data [NumCommits];

  logic [Xlen-1:0] fe_pc;
  logic            fe_redirected;
  logic            ready_at_drive;
  int              seen;
  int              fetched;
  int              errors;
  int              redirects;

  backend_top #(.Xlen(Xlen), .MulStepBits(MulStepBits)) dut (
    .clk_i,
    .rst_ni,
    .fetch_valid_i      (fetch_valid),
    .fetch_redirected_i (fetch_redirected),
    .fetch_pc_i         (fetch_pc),
    .fetch_imm_i        (fetch_imm),
    .fetch_op_i         (fetch_op),
    .fetch_rd_i         (fetch_rd),
    .fetch_rs1_i        (fetch_rs1),
    .fetch_rs2_i        (fetch_rs2),
    .fetch_ready_o      (fetch_ready),
    .redirect_valid_o   (redirect_valid),
    .redirect_pc_o      (redirect_pc),
    .commit_valid_o     (commit_valid),
    .commit_pc_o        (commit_pc),
    .commit_rd_o        (commit_rd),
    .commit_data_o      (commit_data)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Program and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic build_program();
    int unsigned kind;
    int unsigned tgt;
    for (int i = 0; i < ProgWords; i++) begin
      kind        = $urandom % 16;
      prog_rd[i]  = RegAddrW'($urandom % 8);
      prog_rs1[i] = RegAddrW'($urandom % 8);
      prog_rs2[i] = RegAddrW'($urandom % 8);
      prog_imm[i] = Xlen'($urandom % 4096) - Xlen'(2048);
      if (kind < 3) prog_op[i] = OP_ADD;
      else if (kind < 4) prog_op[i] = OP_SUB;
      else if (kind < 5) prog_op[i] = OP_AND;
      else if (kind < 6) prog_op[i] = OP_XOR;
      else if (kind < 9) prog_op[i] = OP_ADDI;
      else if (kind < 11) prog_op[i] = OP_MUL;
      else if (kind < 13) prog_op[i] = OP_BEQ;
      else if (kind < 14) prog_op[i] = OP_JAL;
      else prog_op[i] = OP_ADDI;
      // Often consume the previous result straight away
      if (i > 0 && ($urandom % 2) == 0) begin
        prog_rs1[i] = prog_rd[i-1];
      end
      // Last word jumps back so the PC never leaves the image
      if (i == ProgWords - 1) begin
        prog_op[i] = OP_JAL;
      end
      if (prog_op[i] == OP_BEQ || prog_op[i] == OP_JAL) begin
        tgt = $urandom % ProgWords;
        if (tgt == i) begin
          tgt = (tgt + 1) % ProgWords;
        end
        prog_imm[i] = Xlen'(tgt * PcStep) - Xlen'(i * PcStep);
      end
    end
  endtask

  task automatic run_model();
    logic [Xlen-1:0]     regs [NumRegs];
    logic [Xlen-1:0]     pc;
    logic [Xlen-1:0]     next_pc;
    logic [Xlen-1:0]     a;
    logic [Xlen-1:0]     b;
    logic [Xlen-1:0]     val;
    logic [RegAddrW-1:0] rd;
    int unsigned         idx;
    for (int r = 0; r < NumRegs; r++) begin
      regs[r] = '0;
    end
    pc = '0;
    for (int n = 0; n < NumCommits; n++) begin
      idx     = int'(pc[7:2]);
      a       = regs[prog_rs1[idx]];
      b       = regs[prog_rs2[idx]];
      rd      = prog_rd[idx];
      next_pc = pc + Xlen'(PcStep);
      case (prog_op[idx])
        OP_ADD:  val = a + b;
        OP_SUB:  val = a - b;
        OP_AND:  val = a & b;
        OP_XOR:  val = a ^ b;
        OP_ADDI: val = a + prog_imm[idx];
        OP_MUL:  val = a * b;
        OP_BEQ: begin
          // Branch reports its link value but writes nothing
          val = pc + Xlen'(PcStep);
          rd  = '0;
          if (a == b) begin
            next_pc = pc + prog_imm[idx];
          end
        end
        default: begin
          val     = pc + Xlen'(PcStep);
          next_pc = pc + prog_imm[idx];
        end
      endcase
      exp_pc[n]   = pc;
      exp_rd[n]   = rd;
      exp_data[n] = val;
      if (rd != '0) begin
        regs[rd] = val;
      end
      pc = next_pc;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Frontend driver and commit checker
  //////////////////////////////////////////////////////////////////////

  task automatic check_commit();
    if (commit_valid) begin
      if (commit_pc !== exp_pc[seen]) begin
        errors++;
        $display("** Error [commit pc] commit %0d: expected %h, actual %h",
                 seen, exp_pc[seen], commit_pc);
      end
      if (commit_rd !== exp_rd[seen]) begin
        errors++;
        $display("** Error [commit rd] commit %0d: expected %0d, actual %0d",
                 seen, exp_rd[seen], commit_rd);
      end
      if (commit_data !== exp_data[seen]) begin
        errors++;
        $display("** Error [commit data] commit %0d: expected %h, actual %h",
                 seen, exp_data[seen], commit_data);
      end
      seen++;
    end
  endtask

  task automatic drive_frontend();
    int unsigned idx;
    // Step past the word taken at the last rising edge
    if (fetch_valid && ready_at_drive) begin
      // Words on the architectural path follow the model's PC sequence
      if (fetched < NumCommits && fe_pc == exp_pc[fetched]) begin
        fetched++;
      end
      fe_pc         = fe_pc + Xlen'(PcStep);
      fe_redirected = 1'b0;
    end
    if (redirect_valid) begin
      if (fetched < NumCommits && redirect_pc !== exp_pc[fetched]) begin
        errors++;
        $display("** Error [redirect pc] fetch %0d: expected %h, actual %h",
                 fetched, exp_pc[fetched], redirect_pc);
      end
      fe_pc         = redirect_pc;
      fe_redirected = 1'b1;
      redirects++;
    end
    idx              = int'(fe_pc[7:2]);
    fetch_valid      = ($urandom % 4) != 0;
    fetch_pc         = fe_pc;
    fetch_op         = prog_op[idx];
    fetch_rd         = prog_rd[idx];
    fetch_rs1        = prog_rs1[idx];
    fetch_rs2        = prog_rs2[idx];
    fetch_imm        = prog_imm[idx];
    fetch_redirected = fe_redirected;
    // Ready depends on DUT state only, so it holds until the next rising edge
    ready_at_drive   = fetch_ready;
  endtask

  initial begin
    int cycles;
    void'($urandom(2659));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    fetch_valid      = 1'b0;
    fetch_redirected = 1'b0;
    fetch_pc         = '0;
    fetch_imm        = '0;
    fetch_op         = OP_ADD;
    fetch_rd         = '0;
    fetch_rs1        = '0;
    fetch_rs2        = '0;
    fe_pc            = '0;
    fe_redirected    = 1'b0;
    ready_at_drive   = 1'b0;
    seen             = 0;
    fetched          = 0;
    errors           = 0;
    redirects        = 0;

    build_program();
    run_model();

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Decode register starts empty, so fetch is open out of reset
    if (fetch_ready !== 1'b1) begin
      errors++;
      $display("** Error [reset ready]: expected 1, actual %b", fetch_ready);
    end

    cycles = 0;
    while (seen < NumCommits && cycles < MaxCycles) begin
      @(negedge clk_i);
      check_commit();
      drive_frontend();
      cycles++;
    end

    if (seen < NumCommits) begin
      errors++;
      $display("Timeout after %0d cycles, only %0d of %0d commits seen",
               cycles, seen, NumCommits);
    end
    if (redirects == 0) begin
      errors++;
      $display("No redirect was raised during the run");
    end
    $display("Commits checked: %0d, redirects: %0d, errors: %0d", seen, redirects, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* backend.f */
source/backend_pkg.sv
source/alu.sv
source/mul_unit.sv
source/reg_file.sv
source/issue_ctrl.sv
source/ex_pipe.sv
source/backend_top.sv
sim/backend_props.sv
sim/backend_tb.sv

/* Makefile */
# Verilator simulation of the execute backend

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= backend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
